/* files.f */
+incdir+hw
+incdir+tests
hw/ex_pkg.sv
hw/int_alu.sv
hw/mul_unit.sv
hw/ex_combine.sv
hw/ex_stage.sv
tests/tb_ex_stage.sv

/* hw/ex_combine.sv */
`timescale 1ns/1ps

module ex_combine import ex_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_in,
	input  logic     ready_in,
	input  logic     branch,
	input  logic     reg_w_en,
	input  xlen_t    pc,
	input  xlen_t    alu_result,
	input  xlen_t    branch_target,
	input  xlen_t    mul_result,
	input  reg_idx_t rdest,
	input  logic     mul_pending,
	input  logic     mul_ready,
	output logic     ready_out,
	output logic     valid_out,
	output logic     reg_w_en_out,
	output logic     redirect,
	output xlen_t    result,
	output xlen_t    pc_out,
	output xlen_t    redirect_pc,
	output reg_idx_t rdest_out
);

	logic  accept;
	xlen_t sel_result;

	// stall while a product is still being built
	assign ready_out  = ready_in & ~mul_pending;
	assign accept     = valid_in & ready_out;
	assign sel_result = mul_ready ? mul_result : alu_result;

	assign redirect    = accept & branch & (alu_result != '0);
	assign redirect_pc = branch_target;

	always_ff @(posedge clk) begin
		if (reset)
			valid_out <= 1'b0;
		else if (ready_in)
			valid_out <= accept;
	end

	always_ff @(posedge clk) begin
		if (ready_in) begin
			result       <= sel_result;
			pc_out       <= pc;
			rdest_out    <= rdest;
			reg_w_en_out <= reg_w_en;
		end
	end

endmodule

/* hw/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// architectural widths
`define XLEN       64
`define WORD_W     32
`define REG_IDX_W  5
`define BIMM_W     12 // branch offset bits 12:1

// one shift-add step per multiplier bit
`define MUL_CYCLES 64

`endif

/* hw/ex_pkg.sv */
`include "ex_macros.svh"

package ex_pkg;

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	typedef enum logic [4:0] {
		OP_ADD   = 5'd0,
		OP_ADDW  = 5'd1,
		OP_SLL   = 5'd2,
		OP_SLLW  = 5'd3,
		OP_SRA   = 5'd4,
		OP_SRAW  = 5'd5,
		OP_SRL   = 5'd6,
		OP_SRLW  = 5'd7,
		OP_AND   = 5'd8,
		OP_OR    = 5'd9,
		OP_XOR   = 5'd10,
		OP_SLT   = 5'd11,
		OP_SLTU  = 5'd12,
		OP_EQ    = 5'd13,
		OP_NE    = 5'd14,
		OP_GE    = 5'd15,
		OP_GEU   = 5'd16,
		OP_SUB   = 5'd17,
		OP_SUBW  = 5'd18,
		OP_MUL   = 5'd19,
		OP_MULH  = 5'd20, // high half of signed product
		OP_MULHU = 5'd21,
		OP_MULW  = 5'd22
	} alu_op_t;

	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_RUN,
		MUL_DONE
	} mul_state_t;

	// word result back to full width
	function automatic xlen_t sext_w(input logic [`WORD_W-1:0] w);
		return {{(`XLEN-`WORD_W){w[`WORD_W-1]}}, w};
	endfunction

endpackage

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage import ex_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               valid_in,
	output logic               ready_out,
	input  alu_op_t            op,
	input  xlen_t              src_a,
	input  xlen_t              src_b,
	input  xlen_t              pc,
	input  logic [`BIMM_W-1:0] bimm,
	input  logic               branch,
	input  reg_idx_t           rdest,
	input  logic               reg_w_en,
	input  logic               ready_in,
	output logic               valid_out,
	output xlen_t              result,
	output xlen_t              pc_out,
	output reg_idx_t           rdest_out,
	output logic               reg_w_en_out,
	output logic               redirect,
	output xlen_t              redirect_pc
);

	xlen_t alu_result;
	xlen_t branch_target;
	xlen_t mul_result;
	logic  mul_pending;
	logic  mul_ready;

	int_alu u_alu (
		.op            (op),
		.src_a         (src_a),
		.src_b         (src_b),
		.pc            (pc),
		.bimm          (bimm),
		.alu_result    (alu_result),
		.branch_target (branch_target)
	);

	mul_unit u_mul (
		.clk         (clk),
		.reset       (reset),
		.valid_in    (valid_in),
		.ready_in    (ready_in),
		.op          (op),
		.src_a       (src_a),
		.src_b       (src_b),
		.mul_pending (mul_pending),
		.mul_ready   (mul_ready),
		.mul_result  (mul_result)
	);

	ex_combine u_combine (
		.clk           (clk),
		.reset         (reset),
		.valid_in      (valid_in),
		.ready_in      (ready_in),
		.branch        (branch),
		.reg_w_en      (reg_w_en),
		.pc            (pc),
		.alu_result    (alu_result),
		.branch_target (branch_target),
		.mul_result    (mul_result),
		.rdest         (rdest),
		.mul_pending   (mul_pending),
		.mul_ready     (mul_ready),
		.ready_out     (ready_out),
		.valid_out     (valid_out),
		.reg_w_en_out  (reg_w_en_out),
		.redirect      (redirect),
		.result        (result),
		.pc_out        (pc_out),
		.redirect_pc   (redirect_pc),
		.rdest_out     (rdest_out)
	);

endmodule

/* hw/int_alu.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module int_alu import ex_pkg::*; (
	input  alu_op_t            op,
	input  xlen_t              src_a,
	input  xlen_t              src_b,
	input  xlen_t              pc,
	input  logic [`BIMM_W-1:0] bimm,
	output xlen_t              alu_result,
	output xlen_t              branch_target
);

	logic [$clog2(`XLEN)-1:0]   sh;
	logic [$clog2(`WORD_W)-1:0] sh_w;
	logic [`WORD_W-1:0]         a_w;
	logic [`WORD_W-1:0]         b_w;
	logic [`WORD_W-1:0]         w_add;
	logic [`WORD_W-1:0]         w_sub;
	logic [`WORD_W-1:0]         w_sll;
	logic [`WORD_W-1:0]         w_srl;
	logic [`WORD_W-1:0]         w_sra;

	assign sh   = src_b[$clog2(`XLEN)-1:0];
	assign sh_w = src_b[$clog2(`WORD_W)-1:0]; // word shifts ignore bit 5
	assign a_w  = src_a[`WORD_W-1:0];
	assign b_w  = src_b[`WORD_W-1:0];

	assign w_add = a_w + b_w;
	assign w_sub = a_w - b_w;
	assign w_sll = a_w << sh_w;
	assign w_srl = a_w >> sh_w;
	assign w_sra = $signed(a_w) >>> sh_w;

	always_comb begin
		case (op)
			OP_ADD:  alu_result = src_a + src_b;
			OP_ADDW: alu_result = sext_w(w_add);
			OP_SLL:  alu_result = src_a << sh;
			OP_SLLW: alu_result = sext_w(w_sll);
			OP_SRA:  alu_result = $signed(src_a) >>> sh;
			OP_SRAW: alu_result = sext_w(w_sra);
			OP_SRL:  alu_result = src_a >> sh;
			OP_SRLW: alu_result = sext_w(w_srl);
			OP_AND:  alu_result = src_a & src_b;
			OP_OR:   alu_result = src_a | src_b;
			OP_XOR:  alu_result = src_a ^ src_b;
			OP_SLT:  alu_result = xlen_t'($signed(src_a) < $signed(src_b));
			OP_SLTU: alu_result = xlen_t'(src_a < src_b);
			OP_EQ:   alu_result = xlen_t'(src_a == src_b);
			OP_NE:   alu_result = xlen_t'(src_a != src_b);
			OP_GE:   alu_result = xlen_t'($signed(src_a) >= $signed(src_b));
			OP_GEU:  alu_result = xlen_t'(src_a >= src_b);
			OP_SUB:  alu_result = src_a - src_b;
			OP_SUBW: alu_result = sext_w(w_sub);
			default: alu_result = '0; // multiplies come from mul_unit
		endcase
	end

	// offset is in halfwords
	assign branch_target = pc + {{(`XLEN-`BIMM_W-1){bimm[`BIMM_W-1]}}, bimm, 1'b0};

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module mul_unit import ex_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    valid_in,
	input  logic    ready_in,
	input  alu_op_t op,
	input  xlen_t   src_a,
	input  xlen_t   src_b,
	output logic    mul_pending,
	output logic    mul_ready,
	output xlen_t   mul_result
);

	mul_state_t                     state;
	logic [$clog2(`MUL_CYCLES)-1:0] cnt;
	logic [2*`XLEN-1:0]             prod;
	logic [2*`XLEN-1:0]             prod_fix;
	xlen_t                          mcand;
	logic                           neg;
	logic                           is_mul;
	logic                           signed_op;
	logic                           start;
	logic                           a_neg;
	logic                           b_neg;
	xlen_t                          mag_a;
	xlen_t                          mag_b;
	logic [`XLEN:0]                 sum;

	assign is_mul    = op inside {OP_MUL, OP_MULH, OP_MULHU, OP_MULW};
	assign signed_op = (op == OP_MULH) || (op == OP_MULW); // low half is sign-agnostic
	assign start     = (state == MUL_IDLE) && valid_in && is_mul;

	assign a_neg = signed_op & src_a[`XLEN-1];
	assign b_neg = signed_op & src_b[`XLEN-1];
	assign mag_a = a_neg ? -src_a : src_a;
	assign mag_b = b_neg ? -src_b : src_b;

	// add multiplicand into the upper half when the current multiplier bit is set
	assign sum = {1'b0, prod[2*`XLEN-1:`XLEN]} + ({1'b0, mcand} & {(`XLEN+1){prod[0]}});

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= MUL_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				MUL_IDLE: begin
					if (start) begin
						state <= MUL_RUN;
						cnt   <= '0;
					end
				end
				MUL_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == `MUL_CYCLES-1)
						state <= MUL_DONE;
				end
				MUL_DONE: begin
					if (mul_ready && ready_in) // same edge the stage takes the item
						state <= MUL_IDLE;
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			prod  <= {{`XLEN{1'b0}}, mag_b}; // multiplier sits in the low half
			mcand <= mag_a;
			neg   <= a_neg ^ b_neg;
		end else if (state == MUL_RUN) begin
			prod <= {sum, prod[`XLEN-1:1]};
		end
	end

	assign prod_fix = neg ? -prod : prod;

	always_comb begin
		case (op)
			OP_MULH,
			OP_MULHU: mul_result = prod_fix[2*`XLEN-1:`XLEN];
			OP_MULW:  mul_result = sext_w(prod_fix[`WORD_W-1:0]);
			default:  mul_result = prod_fix[`XLEN-1:0];
		endcase
	end

	assign mul_pending = valid_in && is_mul && (state != MUL_DONE);
	assign mul_ready   = valid_in && is_mul && (state == MUL_DONE);

endmodule

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_ex_stage -o sim_ex_stage
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_ex_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* tests/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic xlen_t sign_ext32(input logic [31:0] w);
	return {{32{w[31]}}, w};
endfunction

function automatic xlen_t model_alu(input alu_op_t op, input xlen_t a, input xlen_t b);
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	logic signed [31:0] sa_w;
	logic [31:0]        r_w;
	sa   = a;
	sb   = b;
	sa_w = a[31:0];
	case (op)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_SLL:  return a << b[5:0];
		OP_SRL:  return a >> b[5:0];
		OP_SRA:  return sa >>> b[5:0];
		OP_AND:  return a & b;
		OP_OR:   return a | b;
		OP_XOR:  return a ^ b;
		OP_SLT:  return (sa < sb) ? 64'd1 : 64'd0;
		OP_SLTU: return (a < b) ? 64'd1 : 64'd0;
		OP_EQ:   return (a == b) ? 64'd1 : 64'd0;
		OP_NE:   return (a != b) ? 64'd1 : 64'd0;
		OP_GE:   return (sa >= sb) ? 64'd1 : 64'd0;
		OP_GEU:  return (a >= b) ? 64'd1 : 64'd0;
		OP_ADDW: r_w = a[31:0] + b[31:0];
		OP_SUBW: r_w = a[31:0] - b[31:0];
		OP_SLLW: r_w = a[31:0] << b[4:0]; // only 5 shift bits
		OP_SRLW: r_w = a[31:0] >> b[4:0];
		OP_SRAW: r_w = sa_w >>> b[4:0];
		default: return '0;
	endcase
	return sign_ext32(r_w);
endfunction

function automatic xlen_t model_mul(input alu_op_t op, input xlen_t a, input xlen_t b);
	logic signed [127:0] wa;
	logic signed [127:0] wb;
	logic signed [127:0] ps;
	logic [127:0]        pu;
	wa = {{64{a[63]}}, a};
	wb = {{64{b[63]}}, b};
	ps = wa * wb;
	pu = {64'd0, a} * {64'd0, b};
	case (op)
		OP_MUL:   return pu[63:0];
		OP_MULH:  return ps[127:64];
		OP_MULHU: return pu[127:64];
		OP_MULW:  return sign_ext32(pu[31:0]);
		default:  return '0;
	endcase
endfunction

function automatic xlen_t model_target(input xlen_t pc, input logic [`BIMM_W-1:0] imm);
	logic signed [63:0] offset;
	offset = $signed(imm); // count of halfwords
	return pc + offset * 2;
endfunction

`endif

/* tests/tb_ex_stage.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage import ex_pkg::*; ();

	localparam int N_ITEMS     = 400;
	localparam int HALF        = 10;
	localparam int WATCHDOG_NS = N_ITEMS * (`MUL_CYCLES + 8) * 20 * 4;

	typedef struct packed {
		xlen_t    result;
		xlen_t    pc;
		reg_idx_t rdest;
		logic     w_en;
	} exp_item_t;

	logic               clk;
	logic               reset;
	logic               valid_in;
	alu_op_t            op;
	xlen_t              src_a;
	xlen_t              src_b;
	xlen_t              pc;
	logic [`BIMM_W-1:0] bimm;
	logic               branch;
	reg_idx_t           rdest;
	logic               reg_w_en;
	logic               ready_in;
	logic               ready_out;
	logic               valid_out;
	xlen_t              result;
	xlen_t              pc_out;
	reg_idx_t           rdest_out;
	logic               reg_w_en_out;
	logic               redirect;
	xlen_t              redirect_pc;

	logic [31:0]  lfsr;
	exp_item_t    exp_q[$];
	int           n_in;
	int           n_out;
	int           mul_wait; // samples since the current item appeared
	logic         accepted;

	`include "tb_model.svh"

	ex_stage UUT (.*);

	initial clk = 1'b0;
	always #(HALF) clk = ~clk;

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	// true with probability 1 in 2**n
	function automatic logic chance(input int n);
		return rand_bits(n) == 64'd0;
	endfunction

	function automatic xlen_t rand_operand();
		xlen_t v;
		if (chance(3)) begin
			case (3'(rand_bits(3)))
				3'd0:    v = '0;
				3'd1:    v = '1;
				3'd2:    v = 64'h8000_0000_0000_0000;
				3'd3:    v = 64'h7fff_ffff_ffff_ffff;
				3'd4:    v = 64'hffff_ffff_8000_0000;
				3'd5:    v = 64'd1;
				3'd6:    v = 64'h0000_0000_7fff_ffff;
				default: v = 64'h0000_0000_8000_0000;
			endcase
		end else begin
			v = rand_bits(64);
		end
		return v;
	endfunction

	task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "data mismatch on %s", name);
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "index mismatch on %s", name);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "bit mismatch on %s", name);
		end
	endtask

	task automatic new_item();
		logic [4:0] sel;
		sel = 5'(rand_bits(5));
		if (sel < 5'd6)
			op = alu_op_t'(5'd19 + 5'(rand_bits(2))); // one of the multiplies
		else if (sel == 5'd6)
			op = alu_op_t'(5'd23 + 5'(rand_bits(3))); // undefined code
		else
			op = alu_op_t'(5'(rand_bits(5) % 64'd19));
		src_a    = rand_operand();
		src_b    = rand_operand();
		pc       = rand_bits(62) << 2;
		bimm     = `BIMM_W'(rand_bits(`BIMM_W));
		branch   = chance(2);
		rdest    = reg_idx_t'(rand_bits(5));
		reg_w_en = chance(1);
		valid_in = 1'b1;
		mul_wait = 0;
	endtask

	task automatic drive_inputs();
		// producer holds an item until it is taken
		if (!valid_in || accepted) begin
			if (n_in < N_ITEMS && !chance(3))
				new_item();
			else
				valid_in = 1'b0;
		end
		ready_in = !chance(2);
	endtask

	task automatic sample_and_check();
		exp_item_t item;
		logic      is_mul_op;
		logic      exp_ready;
		logic      exp_redir;
		is_mul_op = op inside {OP_MUL, OP_MULH, OP_MULHU, OP_MULW};
		check_bit("valid_out", valid_out, exp_q.size() != 0);
		if (valid_out) begin
			// held outputs stay on the front entry
			item = exp_q[0];
			check_data("result", result, item.result);
			check_data("pc_out", pc_out, item.pc);
			check_idx("rdest_out", rdest_out, item.rdest);
			check_bit("reg_w_en_out", reg_w_en_out, item.w_en);
			if (ready_in) begin
				exp_q.delete(0);
				n_out++;
			end
		end
		exp_ready = ready_in && !(valid_in && is_mul_op && mul_wait <= `MUL_CYCLES);
		check_bit("ready_out", ready_out, exp_ready);
		accepted  = valid_in && ready_out;
		exp_redir = accepted && branch && (model_alu(op, src_a, src_b) != '0);
		check_bit("redirect", redirect, exp_redir);
		if (exp_redir)
			check_data("redirect_pc", redirect_pc, model_target(pc, bimm));
		if (accepted) begin
			item.result = is_mul_op ? model_mul(op, src_a, src_b) : model_alu(op, src_a, src_b);
			item.pc     = pc;
			item.rdest  = rdest;
			item.w_en   = reg_w_en;
			exp_q.push_back(item);
			n_in++;
		end else if (valid_in) begin
			mul_wait++;
		end
	endtask

	initial begin
		lfsr     = 32'h15818aa9;
		reset    = 1'b1;
		valid_in = 1'b0;
		op       = OP_ADD;
		src_a    = '0;
		src_b    = '0;
		pc       = '0;
		bimm     = '0;
		branch   = 1'b0;
		rdest    = '0;
		reg_w_en = 1'b0;
		ready_in = 1'b0;
		n_in     = 0;
		n_out    = 0;
		mul_wait = 0;
		accepted = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		#(HALF / 2);
		check_bit("valid_out", valid_out, 1'b0);
		check_bit("redirect", redirect, 1'b0);
		while (n_out < N_ITEMS) begin
			@(negedge clk);
			drive_inputs();
			#(HALF / 2); // well clear of both edges
			sample_and_check();
		end
		@(negedge clk);
		if (valid_out !== 1'b0) begin
			$display("stage still holds an item after the last expected one left");
			$display("=== FAIL ===");
			$fatal(1, "leftover item");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: stage stopped delivering items");
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

endmodule
